// ==== lb_pkg.sv ====
// Shared tag and control word widths, slot message type codes and the control word union
`default_nettype none

package lb_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Slot tag as handed out by a core
  localparam int TAG_WIDTH      = 8;
  // One control word from the cores, type nibble on top
  localparam int CTRL_WIDTH     = 36;
  localparam int MSG_TYPE_WIDTH = 4;

  //////////////////////////////////////////////////
  // Message types
  //////////////////////////////////////////////////

  // Core offers a run of fresh slots, tags 0 upward
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_SLOT_INIT = 4'h1;
  // Core hands back one slot it finished with
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_SLOT_FREE = 4'h2;

  typedef logic [TAG_WIDTH-1:0] lb_tag_t;

  // Free view with the returned tag in the low byte
  typedef struct packed {
    logic [MSG_TYPE_WIDTH-1:0]                      msg_type;
    logic [CTRL_WIDTH-MSG_TYPE_WIDTH-TAG_WIDTH-1:0] rsvd;
    lb_tag_t                                        tag;
  } lb_free_msg_t;

  // Init view with the slot count in bits 15 to 8
  typedef struct packed {
    logic [MSG_TYPE_WIDTH-1:0]                        msg_type;
    logic [CTRL_WIDTH-MSG_TYPE_WIDTH-2*TAG_WIDTH-1:0] rsvd_hi;
    logic [TAG_WIDTH-1:0]                             slot_cnt;
    logic [TAG_WIDTH-1:0]                             rsvd_lo;
  } lb_init_msg_t;

  // Same word, read one way or the other by its type nibble
  typedef union packed {
    lb_free_msg_t free_msg;
    lb_init_msg_t init_msg;
  } lb_ctrl_msg_u;

endpackage

`default_nettype wire

// ==== lb_ctrl_decoder.sv ====
// Control word decoder that turns core slot messages into slot tag pushes
`timescale 1ns/1ps
`default_nettype none

module lb_ctrl_decoder #(
  parameter  int CORE_COUNT = 4,
  localparam int CORE_W     = $clog2(CORE_COUNT)
) (
  input  wire                       clk,
  input  wire                       rst_n,

  // Control messages from the cores, tuser names the sender
  input  wire lb_pkg::lb_ctrl_msg_u ctrl_s_tdata,
  input  wire [CORE_W-1:0]          ctrl_s_tuser,
  input  wire                       ctrl_s_tvalid,
  output wire                       ctrl_s_tready,

  // One-cycle push strobe toward the slot store
  output logic                      push_valid,
  output logic [CORE_W-1:0]         push_core,
  output lb_pkg::lb_tag_t           push_tag
);

  import lb_pkg::*;

  // Pushes still owed after the one on the output now
  logic [TAG_WIDTH-1:0]      init_left;
  logic [TAG_WIDTH-1:0]      init_cnt;
  logic [MSG_TYPE_WIDTH-1:0] msg_type;
  logic                      accept;

  // Type nibble sits in the same place in both views
  assign msg_type = ctrl_s_tdata.free_msg.msg_type;
  assign init_cnt = ctrl_s_tdata.init_msg.slot_cnt;

  // No new word while an init run is still being expanded
  assign ctrl_s_tready = (init_left == '0);
  assign accept        = ctrl_s_tvalid && ctrl_s_tready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      push_valid <= 1'b0;
      init_left  <= '0;
    end else if (init_left != '0) begin
      // Mid-run, one more tag this cycle
      push_valid <= 1'b1;
      init_left  <= init_left - 1'b1;
    end else if (accept && msg_type == MSG_SLOT_FREE) begin
      push_valid <= 1'b1;
    end else if (accept && msg_type == MSG_SLOT_INIT && init_cnt != '0) begin
      push_valid <= 1'b1;
      init_left  <= init_cnt - 1'b1;
    end else begin
      // Idle, unknown type, or a zero-count init
      push_valid <= 1'b0;
    end
  end

  // Push payload, tag counts up during an init run
  always_ff @(posedge clk) begin
    if (accept) begin
      push_core <= ctrl_s_tuser;
      push_tag  <= (msg_type == MSG_SLOT_FREE) ? ctrl_s_tdata.free_msg.tag : '0;
    end else if (init_left != '0) begin
      push_tag  <= push_tag + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== lb_slot_store.sv ====
// Per-core circular FIFOs of free slot tags with counts, valid flags, insert errors and flush
`timescale 1ns/1ps
`default_nettype none

module lb_slot_store #(
  parameter  int CORE_COUNT = 4,
  parameter  int SLOT_COUNT = 4,
  localparam int CORE_W     = $clog2(CORE_COUNT)
) (
  input  wire                                   clk,
  input  wire                                   rst_n,

  // Tag pushes from the decoder, always accepted
  input  wire                                   push_valid,
  input  wire [CORE_W-1:0]                      push_core,
  input  wire lb_pkg::lb_tag_t                  push_tag,

  // Head pops from the lookup
  input  wire                                   pop,
  input  wire [CORE_W-1:0]                      pop_core,

  // One-cycle flush per core from the host registers
  input  wire [CORE_COUNT-1:0]                  slots_flush,

  // Flat status buses, TAG_WIDTH bits per core
  output wire [CORE_COUNT*lb_pkg::TAG_WIDTH-1:0] slot_heads,
  output wire [CORE_COUNT*lb_pkg::TAG_WIDTH-1:0] slot_counts,
  output wire [CORE_COUNT-1:0]                  slot_valids,
  output wire [CORE_COUNT-1:0]                  ins_errs
);

  import lb_pkg::*;

  localparam int PTR_W = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;
  localparam int CNT_W = $clog2(SLOT_COUNT + 1);

  // Wrap at the FIFO depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(SLOT_COUNT - 1)) ? '0 : ptr + 1'b1;
  endfunction

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_core
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] cnt;
    logic             err;
    logic             hit_push;
    logic             hit_pop;
    logic             push_ok;
    lb_tag_t          mem [SLOT_COUNT];

    // Flush beats any push or pop in the same cycle
    assign hit_push = push_valid && (push_core == CORE_W'(c)) && !slots_flush[c];
    assign hit_pop  = pop && (pop_core == CORE_W'(c)) && (cnt != '0) && !slots_flush[c];
    // A full FIFO still takes a push when its head leaves this cycle
    assign push_ok  = hit_push && ((cnt != CNT_W'(SLOT_COUNT)) || hit_pop);

    always_ff @(posedge clk) begin
      if (!rst_n || slots_flush[c]) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        cnt    <= '0;
        err    <= 1'b0;
      end else begin
        if (push_ok)
          wr_ptr <= ptr_next(wr_ptr);
        if (hit_pop)
          rd_ptr <= ptr_next(rd_ptr);
        // Dropped push, sticky until flushed
        if (hit_push && !push_ok)
          err <= 1'b1;
        cnt <= cnt + CNT_W'(push_ok) - CNT_W'(hit_pop);
      end
    end

    always_ff @(posedge clk) begin
      if (push_ok)
        mem[wr_ptr] <= push_tag;
    end

    // Head is read combinationally by the lookup in its pop cycle
    assign slot_heads[c*TAG_WIDTH +: TAG_WIDTH]  = mem[rd_ptr];
    assign slot_counts[c*TAG_WIDTH +: TAG_WIDTH] = TAG_WIDTH'(cnt);
    assign slot_valids[c]                        = (cnt != '0);
    assign ins_errs[c]                           = err;
  end

endmodule

`default_nettype wire

// ==== lb_rr_lu.sv ====
// Round-robin core lookup that pops one slot tag per packet and stamps the forwarded packet
`timescale 1ns/1ps
`default_nettype none

module lb_rr_lu #(
  parameter  int CORE_COUNT = 4,
  parameter  int DATA_WIDTH = 32,
  localparam int CORE_W     = $clog2(CORE_COUNT)
) (
  input  wire                                    clk,
  input  wire                                    rst_n,

  // Receive stream
  input  wire [DATA_WIDTH-1:0]                   rx_tdata,
  input  wire                                    rx_tvalid,
  output wire                                    rx_tready,
  input  wire                                    rx_tlast,

  // Stamped stream toward the cores
  output wire [DATA_WIDTH-1:0]                   m_tdata,
  output wire [CORE_W-1:0]                       m_tdest,
  output lb_pkg::lb_tag_t                        m_tuser,
  output wire                                    m_tvalid,
  input  wire                                    m_tready,
  output wire                                    m_tlast,

  // Core enables and slot status
  input  wire [CORE_COUNT-1:0]                   enabled_cores,
  input  wire [CORE_COUNT-1:0]                   slot_valids,
  input  wire [CORE_COUNT*lb_pkg::TAG_WIDTH-1:0] slot_heads,

  // Head pop toward the slot store
  output wire                                    pop,
  output wire [CORE_W-1:0]                       pop_core
);

  import lb_pkg::*;

  // Low while waiting for a packet, high while passing it through
  logic              fwd;
  logic [CORE_W-1:0] last_core;
  logic [CORE_W-1:0] sel_core;
  lb_tag_t           sel_tag;

  logic [CORE_COUNT-1:0] eligible;
  logic [CORE_W-1:0]     pick;
  logic                  found;
  logic                  start;

  //////////////////////////////////////////////////
  // Round-robin search
  //////////////////////////////////////////////////

  assign eligible = enabled_cores & slot_valids;

  // First eligible core after the last one chosen, wrapping once
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = '0;
    for (int i = 1; i <= CORE_COUNT; i++) begin
      idx = (int'(last_core) + i) % CORE_COUNT;
      if (!found && eligible[idx]) begin
        found = 1'b1;
        pick  = CORE_W'(idx);
      end
    end
  end

  // Selection and pop share the same edge
  assign start    = !fwd && rx_tvalid && found;
  assign pop      = start;
  assign pop_core = pick;

  //////////////////////////////////////////////////
  // Idle and forward FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fwd       <= 1'b0;
      last_core <= CORE_W'(CORE_COUNT - 1);
    end else if (start) begin
      fwd       <= 1'b1;
      last_core <= pick;
    end else if (fwd && rx_tvalid && m_tready && rx_tlast) begin
      fwd       <= 1'b0;
    end
  end

  // Stamp for the packet, head tag read in the pop cycle
  always_ff @(posedge clk) begin
    if (start) begin
      sel_core <= pick;
      sel_tag  <= slot_heads[pick*TAG_WIDTH +: TAG_WIDTH];
    end
  end

  // Pass-through while forwarding, receive side stalls with m_tready
  assign m_tvalid  = fwd && rx_tvalid;
  assign rx_tready = fwd && m_tready;
  assign m_tdata   = rx_tdata;
  assign m_tlast   = rx_tlast;
  assign m_tdest   = sel_core;
  assign m_tuser   = sel_tag;

endmodule

`default_nettype wire

// ==== lb_host_regs.sv ====
// Host command registers for core enables, flush pulses and slot status readback
`timescale 1ns/1ps
`default_nettype none

module lb_host_regs #(
  parameter int CORE_COUNT = 4
) (
  input  wire                                    clk,
  input  wire                                    rst_n,

  // Host register port
  input  wire [7:0]                              host_cmd,
  input  wire                                    host_cmd_wr_en,
  input  wire [31:0]                             host_cmd_wr_data,
  output logic [31:0]                            host_cmd_rd_data,

  // Status from the slot store
  input  wire [CORE_COUNT*lb_pkg::TAG_WIDTH-1:0] slot_counts,
  input  wire [CORE_COUNT-1:0]                   slot_valids,
  input  wire [CORE_COUNT-1:0]                   ins_errs,

  // Config toward the lookup and the store
  output logic [CORE_COUNT-1:0]                  enabled_cores,
  output logic [CORE_COUNT-1:0]                  slots_flush
);

  import lb_pkg::*;

  localparam logic [7:0] ADDR_ENABLE = 8'd0;
  localparam logic [7:0] ADDR_FLUSH  = 8'd1;
  localparam logic [7:0] ADDR_STATUS = 8'd2;
  // Per-core slot counts start here
  localparam logic [7:0] ADDR_COUNT  = 8'd4;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enabled_cores <= '0;
      slots_flush   <= '0;
    end else begin
      if (host_cmd_wr_en && host_cmd == ADDR_ENABLE)
        enabled_cores <= host_cmd_wr_data[CORE_COUNT-1:0];
      // Flush bits live for one cycle only
      slots_flush <= (host_cmd_wr_en && host_cmd == ADDR_FLUSH) ?
                     host_cmd_wr_data[CORE_COUNT-1:0] : '0;
    end
  end

  // Readback straight from the address, unmapped reads give 0
  always_comb begin
    host_cmd_rd_data = '0;
    if (host_cmd == ADDR_ENABLE)
      host_cmd_rd_data = 32'(enabled_cores);
    else if (host_cmd == ADDR_STATUS)
      host_cmd_rd_data = {16'(ins_errs), 16'(slot_valids)};
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (host_cmd == ADDR_COUNT + 8'(c))
        host_cmd_rd_data = 32'(slot_counts[c*TAG_WIDTH +: TAG_WIDTH]);
    end
  end

endmodule

`default_nettype wire

// ==== lb_pr.sv ====
// Load balancer top level joining decoder, slot store, round-robin lookup and host registers
`timescale 1ns/1ps
`default_nettype none

module lb_pr #(
  parameter  int CORE_COUNT = 4,
  parameter  int SLOT_COUNT = 4,
  parameter  int DATA_WIDTH = 32,
  localparam int CORE_W     = $clog2(CORE_COUNT)
) (
  input  wire                          clk,
  input  wire                          rst_n,

  // Control messages from the cores
  input  wire [lb_pkg::CTRL_WIDTH-1:0] ctrl_s_tdata,
  input  wire [CORE_W-1:0]             ctrl_s_tuser,
  input  wire                          ctrl_s_tvalid,
  output wire                          ctrl_s_tready,

  // Receive stream
  input  wire [DATA_WIDTH-1:0]         rx_tdata,
  input  wire                          rx_tvalid,
  output wire                          rx_tready,
  input  wire                          rx_tlast,

  // Stamped stream toward the cores
  output wire [DATA_WIDTH-1:0]         m_tdata,
  output wire [CORE_W-1:0]             m_tdest,
  output wire [lb_pkg::TAG_WIDTH-1:0]  m_tuser,
  output wire                          m_tvalid,
  input  wire                          m_tready,
  output wire                          m_tlast,

  // Host register port
  input  wire [7:0]                    host_cmd,
  input  wire                          host_cmd_wr_en,
  input  wire [31:0]                   host_cmd_wr_data,
  output wire [31:0]                   host_cmd_rd_data
);

  import lb_pkg::*;

  // Decoder to store
  wire                            push_valid;
  wire [CORE_W-1:0]               push_core;
  wire lb_tag_t                   push_tag;

  // Lookup to store
  wire                            pop;
  wire [CORE_W-1:0]               pop_core;

  // Config and status
  wire [CORE_COUNT-1:0]           enabled_cores;
  wire [CORE_COUNT-1:0]           slots_flush;
  wire [CORE_COUNT*TAG_WIDTH-1:0] slot_heads;
  wire [CORE_COUNT*TAG_WIDTH-1:0] slot_counts;
  wire [CORE_COUNT-1:0]           slot_valids;
  wire [CORE_COUNT-1:0]           ins_errs;

  //////////////////////////////////////////////////
  // Slot producer and store
  //////////////////////////////////////////////////

  lb_ctrl_decoder #(
    .CORE_COUNT(CORE_COUNT)
  ) decoder_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_s_tdata (ctrl_s_tdata),
    .ctrl_s_tuser (ctrl_s_tuser),
    .ctrl_s_tvalid(ctrl_s_tvalid),
    .ctrl_s_tready(ctrl_s_tready),
    .push_valid   (push_valid),
    .push_core    (push_core),
    .push_tag     (push_tag)
  );

  lb_slot_store #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) store_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_core  (push_core),
    .push_tag   (push_tag),
    .pop        (pop),
    .pop_core   (pop_core),
    .slots_flush(slots_flush),
    .slot_heads (slot_heads),
    .slot_counts(slot_counts),
    .slot_valids(slot_valids),
    .ins_errs   (ins_errs)
  );

  //////////////////////////////////////////////////
  // Packet lookup and host registers
  //////////////////////////////////////////////////

  lb_rr_lu #(
    .CORE_COUNT(CORE_COUNT),
    .DATA_WIDTH(DATA_WIDTH)
  ) lookup_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_tdata     (rx_tdata),
    .rx_tvalid    (rx_tvalid),
    .rx_tready    (rx_tready),
    .rx_tlast     (rx_tlast),
    .m_tdata      (m_tdata),
    .m_tdest      (m_tdest),
    .m_tuser      (m_tuser),
    .m_tvalid     (m_tvalid),
    .m_tready     (m_tready),
    .m_tlast      (m_tlast),
    .enabled_cores(enabled_cores),
    .slot_valids  (slot_valids),
    .slot_heads   (slot_heads),
    .pop          (pop),
    .pop_core     (pop_core)
  );

  lb_host_regs #(
    .CORE_COUNT(CORE_COUNT)
  ) regs_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .host_cmd        (host_cmd),
    .host_cmd_wr_en  (host_cmd_wr_en),
    .host_cmd_wr_data(host_cmd_wr_data),
    .host_cmd_rd_data(host_cmd_rd_data),
    .slot_counts     (slot_counts),
    .slot_valids     (slot_valids),
    .ins_errs        (ins_errs),
    .enabled_cores   (enabled_cores),
    .slots_flush     (slots_flush)
  );

endmodule

`default_nettype wire

// ==== tb_lb_pr.sv ====
// Testbench for the load balancer with a step table, a slot model and stream checks
`timescale 1ns/1ps
`default_nettype none

module tb_lb_pr;

  import lb_pkg::*;

  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 4;
  localparam int DATA_WIDTH = 32;
  localparam int CORE_W     = $clog2(CORE_COUNT);
  localparam int CLK_PERIOD = 40;
  localparam int WAIT_LIMIT = 200;

  // Step kinds, field use per kind
  //   K_CTRL  a core, b message type, c count or tag
  //   K_HWR   a address, b data
  //   K_HRD   a address, b expected readback
  //   K_PKT   a length, b random m_tready stalls
  //   K_BLOCK a length, b core of the releasing free message, c its tag
  localparam logic [2:0] K_CTRL  = 3'd0;
  localparam logic [2:0] K_HWR   = 3'd1;
  localparam logic [2:0] K_HRD   = 3'd2;
  localparam logic [2:0] K_PKT   = 3'd3;
  localparam logic [2:0] K_BLOCK = 3'd4;

  typedef struct packed {
    logic [2:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
  } step_t;

  logic                  clk;
  logic                  rst_n;
  logic [CTRL_WIDTH-1:0] ctrl_s_tdata;
  logic [CORE_W-1:0]     ctrl_s_tuser;
  logic                  ctrl_s_tvalid;
  wire                   ctrl_s_tready;
  logic [DATA_WIDTH-1:0] rx_tdata;
  logic                  rx_tvalid;
  wire                   rx_tready;
  logic                  rx_tlast;
  wire [DATA_WIDTH-1:0]  m_tdata;
  wire [CORE_W-1:0]      m_tdest;
  wire lb_tag_t          m_tuser;
  wire                   m_tvalid;
  logic                  m_tready;
  wire                   m_tlast;
  logic [7:0]            host_cmd;
  logic                  host_cmd_wr_en;
  logic [31:0]           host_cmd_wr_data;
  wire [31:0]            host_cmd_rd_data;

  // Reference slot model
  lb_tag_t               slot_q [CORE_COUNT][$];
  logic [CORE_COUNT-1:0] model_en;
  int                    model_last;

  step_t       steps [$];
  logic [31:0] rng_state;
  int          err_count;
  int          check_count;
  logic        timed_out;

  lb_pr #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT),
    .DATA_WIDTH(DATA_WIDTH)
  ) dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_s_tdata    (ctrl_s_tdata),
    .ctrl_s_tuser    (ctrl_s_tuser),
    .ctrl_s_tvalid   (ctrl_s_tvalid),
    .ctrl_s_tready   (ctrl_s_tready),
    .rx_tdata        (rx_tdata),
    .rx_tvalid       (rx_tvalid),
    .rx_tready       (rx_tready),
    .rx_tlast        (rx_tlast),
    .m_tdata         (m_tdata),
    .m_tdest         (m_tdest),
    .m_tuser         (m_tuser),
    .m_tvalid        (m_tvalid),
    .m_tready        (m_tready),
    .m_tlast         (m_tlast),
    .host_cmd        (host_cmd),
    .host_cmd_wr_en  (host_cmd_wr_en),
    .host_cmd_wr_data(host_cmd_wr_data),
    .host_cmd_rd_data(host_cmd_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers and compare tasks
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Init has its count in bits 15:8, free has its tag in the low byte
  function automatic logic [CTRL_WIDTH-1:0] ctrl_word(input logic [3:0] msg_type,
                                                      input logic [7:0] value);
    if (msg_type == MSG_SLOT_INIT)
      return {msg_type, 16'h0, value, 8'h0};
    return {msg_type, 24'h0, value};
  endfunction

  task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_core(input string name, input logic [CORE_W-1:0] got,
                            input logic [CORE_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input lb_tag_t got, input lb_tag_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Full FIFO drops the tag
  task automatic model_push(input int core, input lb_tag_t tag);
    if (slot_q[core].size() < SLOT_COUNT)
      slot_q[core].push_back(tag);
  endtask

  // Next enabled core holding a tag, searched from the one after the last pick
  function automatic int model_pick();
    int idx;
    for (int i = 1; i <= CORE_COUNT; i++) begin
      idx = (model_last + i) % CORE_COUNT;
      if (model_en[idx] && slot_q[idx].size() != 0)
        return idx;
    end
    return -1;
  endfunction

  task automatic add_step(input logic [2:0] kind, input int a, input int b, input int c);
    step_t st;
    st.kind = kind;
    st.a    = a;
    st.b    = b;
    st.c    = c;
    steps.push_back(st);
  endtask

  //////////////////////////////////////////////////
  // Bus tasks, all entered on a falling edge
  //////////////////////////////////////////////////

  task automatic send_ctrl(input int core, input logic [3:0] msg_type, input logic [7:0] value);
    int guard;
    guard         = 0;
    ctrl_s_tdata  = ctrl_word(msg_type, value);
    ctrl_s_tuser  = CORE_W'(core);
    ctrl_s_tvalid = 1'b1;
    // Ready seen here means the next rising edge takes the word
    while (!ctrl_s_tready && guard < WAIT_LIMIT) begin
      @(negedge clk);
      guard++;
    end
    if (!ctrl_s_tready) begin
      timed_out = 1'b1;
      $display("Timeout: control word for core %0d was never accepted", core);
    end
    @(negedge clk);
    ctrl_s_tvalid = 1'b0;
  endtask

  task automatic wait_ctrl_idle();
    int guard;
    guard = 0;
    while (!ctrl_s_tready && guard < WAIT_LIMIT) begin
      @(negedge clk);
      guard++;
    end
    if (!ctrl_s_tready) begin
      timed_out = 1'b1;
      $display("Timeout: decoder never finished its slot init run");
    end
    // Last push still has to land in the store
    repeat (2) @(negedge clk);
  endtask

  task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
    host_cmd         = addr;
    host_cmd_wr_data = data;
    host_cmd_wr_en   = 1'b1;
    @(negedge clk);
    host_cmd_wr_en = 1'b0;
    // Flush pulse acts one edge after the write
    @(negedge clk);
  endtask

  task automatic host_read(input logic [7:0] addr, input logic [31:0] exp);
    host_cmd = addr;
    @(negedge clk);
    check_reg($sformatf("host_cmd_rd_data[%0h]", addr), host_cmd_rd_data, exp);
  endtask

  // Drives one packet; a release core of 0 or more means it must first sit blocked
  task automatic run_packet(input int len, input logic stall, input int rel_core,
                            input lb_tag_t rel_tag, output int exp_core, output lb_tag_t exp_tag);
    logic [DATA_WIDTH-1:0] words [$];
    int                    sent;
    int                    guard;
    int                    lead;
    logic                  exp_vld;
    logic                  go;
    for (int i = 0; i < len; i++) begin
      rng_state = xorshift32(rng_state);
      words.push_back(rng_state);
    end
    rx_tdata  = words[0];
    rx_tlast  = (len == 1);
    rx_tvalid = 1'b1;
    m_tready  = 1'b1;
    exp_tag   = '0;
    if (rel_core >= 0) begin
      if (model_pick() >= 0) begin
        err_count++;
        $display("Blocked packet step finds an eligible core in the model");
      end
      // Nothing may move while no core can take the packet
      for (int i = 0; i < 20; i++) begin
        #(CLK_PERIOD / 4);
        check_bit("rx_tready", rx_tready, 1'b0);
        check_bit("m_tvalid", m_tvalid, 1'b0);
        @(negedge clk);
      end
      send_ctrl(rel_core, MSG_SLOT_FREE, rel_tag);
      model_push(rel_core, rel_tag);
    end
    exp_core = model_pick();
    if (exp_core >= 0) begin
      exp_tag    = slot_q[exp_core].pop_front();
      model_last = exp_core;
    end else begin
      err_count++;
      $display("Packet step finds no eligible core in the model");
    end
    // One idle cycle for the selection, one more while a freed tag reaches the store
    lead  = (rel_core >= 0) ? 2 : 1;
    sent  = 0;
    guard = 0;
    while (sent < len && guard < WAIT_LIMIT + 4 * len) begin
      if (stall) begin
        rng_state = xorshift32(rng_state);
        m_tready  = (rng_state[1:0] != 2'b00);
      end
      #(CLK_PERIOD / 4);
      exp_vld = (guard >= lead);
      go      = exp_vld && m_tready;
      check_bit("m_tvalid", m_tvalid, exp_vld);
      // Receive side follows m_tready once the packet is forwarding
      check_bit("rx_tready", rx_tready, go);
      if (go) begin
        check_word("m_tdata", m_tdata, words[sent]);
        check_core("m_tdest", m_tdest, CORE_W'(exp_core));
        check_tag("m_tuser", m_tuser, exp_tag);
        check_bit("m_tlast", m_tlast, sent == len - 1);
        sent++;
      end
      @(negedge clk);
      guard++;
      if (sent < len) begin
        rx_tdata = words[sent];
        rx_tlast = (sent == len - 1);
      end
    end
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    m_tready  = 1'b1;
    if (sent < len) begin
      timed_out = 1'b1;
      $display("Timeout: packet sent only %0d of its %0d words to the output", sent, len);
    end
  endtask

  //////////////////////////////////////////////////
  // Step table
  //////////////////////////////////////////////////

  task automatic build_table();
    // Idle after reset
    for (int c = 0; c < CORE_COUNT; c++)
      add_step(K_HRD, 4 + c, 0, 0);
    add_step(K_HRD, 2, 32'h0, 0);
    add_step(K_HRD, 0, 32'h0, 0);
    // Slot init for cores 0, 1 and 3
    add_step(K_CTRL, 0, MSG_SLOT_INIT, 3);
    add_step(K_CTRL, 1, MSG_SLOT_INIT, 4);
    add_step(K_CTRL, 3, MSG_SLOT_INIT, 2);
    add_step(K_HRD, 4, 3, 0);
    add_step(K_HRD, 5, 4, 0);
    add_step(K_HRD, 6, 0, 0);
    add_step(K_HRD, 7, 2, 0);
    add_step(K_HRD, 2, 32'h0000_000B, 0);
    // Round robin over all cores, core 2 empty
    add_step(K_HWR, 0, 32'hF, 0);
    add_step(K_PKT, 1, 0, 0);
    add_step(K_PKT, 3, 0, 0);
    add_step(K_PKT, 2, 0, 0);
    add_step(K_PKT, 4, 0, 0);
    add_step(K_PKT, 1, 0, 0);
    add_step(K_PKT, 2, 0, 0);
    add_step(K_HRD, 4, 1, 0);
    add_step(K_HRD, 5, 2, 0);
    add_step(K_HRD, 7, 0, 0);
    add_step(K_HRD, 2, 32'h0000_0003, 0);
    // Core 0 off, then every eligible FIFO runs dry
    add_step(K_HWR, 0, 32'hE, 0);
    add_step(K_PKT, 2, 0, 0);
    add_step(K_PKT, 3, 0, 0);
    add_step(K_BLOCK, 2, 3, 8'h5A);
    add_step(K_HRD, 4, 1, 0);
    add_step(K_HRD, 7, 0, 0);
    // Overfill core 1, then flush it
    add_step(K_CTRL, 1, MSG_SLOT_INIT, 4);
    add_step(K_CTRL, 1, MSG_SLOT_FREE, 8'h77);
    add_step(K_HRD, 5, 4, 0);
    add_step(K_HRD, 2, 32'h0002_0003, 0);
    add_step(K_HWR, 1, 32'h2, 0);
    add_step(K_HRD, 5, 0, 0);
    add_step(K_HRD, 2, 32'h0000_0001, 0);
    // Long packets under random output stalls
    add_step(K_HWR, 0, 32'hF, 0);
    add_step(K_CTRL, 2, MSG_SLOT_INIT, 4);
    add_step(K_CTRL, 3, MSG_SLOT_INIT, 3);
    add_step(K_PKT, 5, 1, 0);
    add_step(K_PKT, 3, 1, 0);
    add_step(K_PKT, 6, 1, 0);
    add_step(K_PKT, 4, 1, 0);
    add_step(K_PKT, 7, 1, 0);
    add_step(K_PKT, 2, 1, 0);
    add_step(K_HRD, 4, 0, 0);
    add_step(K_HRD, 6, 1, 0);
    add_step(K_HRD, 7, 1, 0);
    add_step(K_HRD, 2, 32'h0000_000C, 0);
    add_step(K_HRD, 0, 32'hF, 0);
  endtask

  initial begin
    step_t   st;
    string   note;
    int      core;
    lb_tag_t tag;
    rst_n            = 1'b0;
    ctrl_s_tdata     = '0;
    ctrl_s_tuser     = '0;
    ctrl_s_tvalid    = 1'b0;
    rx_tdata         = '0;
    rx_tvalid        = 1'b0;
    rx_tlast         = 1'b0;
    m_tready         = 1'b1;
    host_cmd         = '0;
    host_cmd_wr_en   = 1'b0;
    host_cmd_wr_data = '0;
    rng_state        = 32'd49077;
    err_count        = 0;
    check_count      = 0;
    timed_out        = 1'b0;
    model_en         = '0;
    model_last       = CORE_COUNT - 1;
    build_table();

    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("m_tvalid", m_tvalid, 1'b0);
    check_bit("rx_tready", rx_tready, 1'b0);
    check_bit("ctrl_s_tready", ctrl_s_tready, 1'b1);
    $display("Reset check done, %0d errors so far", err_count);

    for (int i = 0; i < steps.size() && !timed_out; i++) begin
      st = steps[i];
      case (st.kind)
        K_CTRL: begin
          send_ctrl(st.a, st.b[3:0], st.c[7:0]);
          if (st.b[3:0] == MSG_SLOT_FREE)
            model_push(st.a, st.c[7:0]);
          else if (st.b[3:0] == MSG_SLOT_INIT)
            for (int t = 0; t < st.c; t++)
              model_push(st.a, lb_tag_t'(t));
          wait_ctrl_idle();
          note = $sformatf("control type %0h to core %0d value %0d", st.b[3:0], st.a, st.c);
        end
        K_HWR: begin
          host_write(st.a[7:0], st.b);
          if (st.a == 0)
            model_en = st.b[CORE_COUNT-1:0];
          else if (st.a == 1)
            for (int c = 0; c < CORE_COUNT; c++)
              if (st.b[c])
                slot_q[c].delete();
          note = $sformatf("host write %0h to address %0d", st.b, st.a);
        end
        K_HRD: begin
          host_read(st.a[7:0], st.b);
          note = $sformatf("host read address %0d", st.a);
        end
        default: begin
          // Plain and blocked packets
          if (st.kind == K_BLOCK)
            run_packet(st.a, 1'b0, st.b, st.c[7:0], core, tag);
          else
            run_packet(st.a, st.b[0], -1, '0, core, tag);
          note = $sformatf("packet of %0d words to core %0d tag %h", st.a, core, tag);
        end
      endcase
      $display("Step %0d done, %s, %0d errors so far", i, note, err_count);
    end

    $display("Checks %0d, errors %0d, timeouts %0d", check_count, err_count, timed_out);
    if (err_count == 0 && !timed_out)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
lb_pkg.sv
lb_ctrl_decoder.sv
lb_slot_store.sv
lb_rr_lu.sv
lb_host_regs.sv
lb_pr.sv
tb_lb_pr.sv

// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing -Wno-fatal
TOP      = tb_lb_pr
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log

SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the testbench printed its pass line
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
